// ==== logic/decode_pkg.sv ====
// Decode package for the instruction-decode queue
// Opcode constants, format and select encodings, and the stored control word

package decode_pkg;

  localparam int INSTR_W = 32;

  // RV32I major opcodes
  localparam logic [6:0] OP_R     = 7'b0110011;
  localparam logic [6:0] OP_I     = 7'b0010011;
  localparam logic [6:0] OP_S     = 7'b0100011;
  localparam logic [6:0] OP_B     = 7'b1100011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_J     = 7'b1101111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA variant

  typedef enum logic [2:0] {
    FMT_R       = 3'd0,
    FMT_I       = 3'd1,
    FMT_S       = 3'd2,
    FMT_B       = 3'd3,
    FMT_U       = 3'd4,
    FMT_J       = 3'd5,
    FMT_ILLEGAL = 3'd7
  } instr_type_t;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_NONE = 2'd0,
    WB_ALU  = 2'd1,
    WB_PC4  = 2'd2  // Link address for jumps
  } wb_sel_t;

  typedef enum logic [1:0] {
    PC_HOLD  = 2'd0,
    PC_PLUS4 = 2'd2,
    PC_ALU   = 2'd3  // Jump target from ALU
  } pc_sel_t;

  // One buffer entry, 14 bits
  typedef struct packed {
    instr_type_t instr_type;
    alu_op_t     alu_sel;
    logic        b_sel;      // Immediate as operand B
    logic        br_un;      // Unsigned branch compare
    wb_sel_t     wb_sel;
    logic        rf_we;
    pc_sel_t     pc_sel;
  } ctrl_word_t;

endpackage

// ==== logic/ctrl_decoder.sv ====
// Control decoder and credit holder
// Accepts instructions over valid/ready, builds the control word and pushes it
// into the buffer, spending one credit per push

module ctrl_decoder #(
  parameter int DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  logic [decode_pkg::INSTR_W-1:0] in_instr,
  output logic                         in_ready,
  output logic                         push,
  output decode_pkg::ctrl_word_t       word,
  input  logic                         credit_return
);

  import decode_pkg::*;

  localparam int CW = $clog2(DEPTH) + 1;

  logic [CW-1:0] credits;
  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  instr_type_t   fmt;

  // Shared R/I table, I-format never selects SUB
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic is_r);
    alu_op_t op;
    op = ADD;
    case (f3)
      3'b000: begin
        if (is_r && f7 == F7_ALT) op = SUB;
        else op = ADD;
      end
      3'b111: op = AND;
      3'b110: op = OR;
      3'b100: op = XOR;
      3'b001: op = SLL;
      3'b101: begin
        if (f7 == F7_ALT) op = SRA;
        else op = SRL;
      end
      3'b010: op = SLT;
      3'b011: op = SLTU;
      default: op = ADD;
    endcase
    return op;
  endfunction

  assign opcode = in_instr[6:0];
  assign funct3 = in_instr[14:12];
  assign funct7 = in_instr[31:25];

  always_comb begin
    case (opcode)
      OP_R:             fmt = FMT_R;
      OP_I:             fmt = FMT_I;
      OP_S:             fmt = FMT_S;
      OP_B:             fmt = FMT_B;
      OP_LUI, OP_AUIPC: fmt = FMT_U;
      OP_J:             fmt = FMT_J;
      default:          fmt = FMT_ILLEGAL;
    endcase
  end

  always_comb begin
    word.instr_type = fmt;
    word.alu_sel    = ADD;
    word.b_sel      = 1'b0;
    word.br_un      = 1'b0;
    word.wb_sel     = WB_NONE;
    word.rf_we      = 1'b0;
    word.pc_sel     = PC_PLUS4;
    case (fmt)
      FMT_R: begin
        word.alu_sel = alu_decode(funct3, funct7, 1'b1);
        word.wb_sel  = WB_ALU;
        word.rf_we   = 1'b1;
      end
      FMT_I: begin
        word.alu_sel = alu_decode(funct3, funct7, 1'b0);
        word.b_sel   = 1'b1;
        word.wb_sel  = WB_ALU;
        word.rf_we   = 1'b1;
      end
      FMT_S: word.b_sel = 1'b1;
      FMT_B: word.br_un = (funct3 == 3'b110) || (funct3 == 3'b111); // BLTU, BGEU
      FMT_U: begin
        word.b_sel  = 1'b1;
        word.wb_sel = WB_ALU;
        word.rf_we  = 1'b1;
      end
      FMT_J: begin
        word.wb_sel = WB_PC4;
        word.rf_we  = 1'b1;
        word.pc_sel = PC_ALU;
      end
      default: word.pc_sel = PC_HOLD; // Illegal opcode stalls the PC
    endcase
  end

  assign in_ready = (credits != '0);
  assign push     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CW'(DEPTH);
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // Both or neither
      endcase
    end
  end

endmodule

// ==== logic/ctrl_buffer.sv ====
// Control word buffer
// Circular store in a synchronous-read memory, one write and one read port;
// each pop hands a credit back to the decoder

module ctrl_buffer #(
  parameter int DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  decode_pkg::ctrl_word_t word,
  input  logic                   pop,
  output logic                   entry_avail,
  output decode_pkg::ctrl_word_t rd_word,
  output logic                   credit_return
);

  import decode_pkg::*;

  localparam int AW = $clog2(DEPTH);

  ctrl_word_t    mem [DEPTH];
  ctrl_word_t    rd_data;
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  // Write port, no full check since credits bound the fill
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= word;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (pop) begin
      rd_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign entry_avail   = (count != '0);
  assign rd_word       = rd_data;
  assign credit_return = pop; // Slot frees as the read is launched

endmodule

// ==== logic/ctrl_issue.sv ====
// Issue stage
// Pops the buffer into a two-entry output stage and presents the oldest
// entry on a valid/ready port

module ctrl_issue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   entry_avail,
  output logic                   pop,
  input  decode_pkg::ctrl_word_t rd_word,
  output logic                   out_valid,
  input  logic                   out_ready,
  output decode_pkg::ctrl_word_t out_word
);

  import decode_pkg::*;

  ctrl_word_t stage [2];
  logic       wr_sel;       // Next slot to fill
  logic       rd_sel;       // Head slot
  logic [1:0] occ;
  logic       pop_inflight; // Read data lands next edge
  logic       fire;
  logic [2:0] load;

  assign fire = out_valid && out_ready;

  // Held words plus the one in flight, against two slots
  // A transfer this cycle frees a slot for the next capture
  assign load = {1'b0, occ} + {2'b0, pop_inflight};
  assign pop  = entry_avail && (load < ({2'b0, fire} + 3'd2));

  always_ff @(posedge clk) begin
    if (pop_inflight) begin
      stage[wr_sel] <= rd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_sel       <= 1'b0;
      rd_sel       <= 1'b0;
      occ          <= '0;
      pop_inflight <= 1'b0;
    end else begin
      pop_inflight <= pop;
      if (pop_inflight) wr_sel <= ~wr_sel;
      if (fire) rd_sel <= ~rd_sel;
      case ({pop_inflight, fire})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  assign out_valid = (occ != '0);
  assign out_word  = stage[rd_sel];

endmodule

// ==== logic/decode_queue.sv ====
// Instruction-decode queue top level
// Decoder feeds a credit-controlled buffer, which the issue stage drains
// into a valid/ready output split into loose control fields

module decode_queue #(
  parameter int DEPTH = 8 // Buffer entries, power of two
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  input  logic [decode_pkg::INSTR_W-1:0] in_instr,
  output logic                           in_ready,
  output logic                           out_valid,
  input  logic                           out_ready,
  output decode_pkg::instr_type_t        out_instr_type,
  output decode_pkg::alu_op_t            out_alu_sel,
  output logic                           out_b_sel,
  output logic                           out_br_un,
  output decode_pkg::wb_sel_t            out_wb_sel,
  output logic                           out_rf_we,
  output decode_pkg::pc_sel_t            out_pc_sel
);

  import decode_pkg::*;

  logic       push;
  logic       pop;
  logic       entry_avail;
  logic       credit_return;
  ctrl_word_t word;
  ctrl_word_t rd_word;
  ctrl_word_t out_word;

  ctrl_decoder #(
    .DEPTH(DEPTH)
  ) decoder_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_ready      (in_ready),
    .push          (push),
    .word          (word),
    .credit_return (credit_return)
  );

  ctrl_buffer #(
    .DEPTH(DEPTH)
  ) buffer_i (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .word          (word),
    .pop           (pop),
    .entry_avail   (entry_avail),
    .rd_word       (rd_word),
    .credit_return (credit_return)
  );

  ctrl_issue issue_i (
    .clk         (clk),
    .rst         (rst),
    .entry_avail (entry_avail),
    .pop         (pop),
    .rd_word     (rd_word),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_word    (out_word)
  );

  assign out_instr_type = out_word.instr_type;
  assign out_alu_sel    = out_word.alu_sel;
  assign out_b_sel      = out_word.b_sel;
  assign out_br_un      = out_word.br_un;
  assign out_wb_sel     = out_word.wb_sel;
  assign out_rf_we      = out_word.rf_we;
  assign out_pc_sel     = out_word.pc_sel;

endmodule

// ==== tb/decode_model.svh ====
// Reference model for the decode-queue testbench
// Control-word decode from the opcode table, expected-word FIFO and a Galois LFSR
// for random stimulus

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

ctrl_word_t  exp_q[$];                  // Accepted, not yet seen at the output
logic [31:0] lfsr_state = 32'h8bdd_7786;

// Expected control word for one instruction
function automatic ctrl_word_t decode_ref(input logic [31:0] instr);
  ctrl_word_t w;
  logic [6:0] op;
  logic [2:0] f3;
  logic       alt;
  logic       is_r;
  logic       is_i;
  op  = instr[6:0];
  f3  = instr[14:12];
  alt = (instr[31:25] == 7'b0100000);
  if (op == OP_R) w.instr_type = FMT_R;
  else if (op == OP_I) w.instr_type = FMT_I;
  else if (op == OP_S) w.instr_type = FMT_S;
  else if (op == OP_B) w.instr_type = FMT_B;
  else if (op == OP_LUI || op == OP_AUIPC) w.instr_type = FMT_U;
  else if (op == OP_J) w.instr_type = FMT_J;
  else w.instr_type = FMT_ILLEGAL;
  is_r = (w.instr_type == FMT_R);
  is_i = (w.instr_type == FMT_I);

  w.alu_sel = ADD;
  if (is_r || is_i) begin
    case (f3)
      3'b000: if (is_r && alt) w.alu_sel = SUB; // I-format has no SUB
      3'b001: w.alu_sel = SLL;
      3'b010: w.alu_sel = SLT;
      3'b011: w.alu_sel = SLTU;
      3'b100: w.alu_sel = XOR;
      3'b101: begin
        if (alt) w.alu_sel = SRA;
        else w.alu_sel = SRL;
      end
      3'b110: w.alu_sel = OR;
      default: w.alu_sel = AND;
    endcase
  end

  w.b_sel = is_i || (w.instr_type == FMT_S) || (w.instr_type == FMT_U);
  w.br_un = (w.instr_type == FMT_B) && (f3[2:1] == 2'b11);
  w.rf_we = is_r || is_i || (w.instr_type == FMT_U) || (w.instr_type == FMT_J);

  if (is_r || is_i || w.instr_type == FMT_U) w.wb_sel = WB_ALU;
  else if (w.instr_type == FMT_J) w.wb_sel = WB_PC4;
  else w.wb_sel = WB_NONE;

  if (w.instr_type == FMT_J) w.pc_sel = PC_ALU;
  else if (w.instr_type == FMT_ILLEGAL) w.pc_sel = PC_HOLD;
  else w.pc_sel = PC_PLUS4;
  return w;
endfunction

// Record the word an accepted instruction must produce
task automatic expect_instr(input logic [31:0] instr);
  exp_q.push_back(decode_ref(instr));
endtask

// One Galois step, returns the bit shifted out
function automatic logic lfsr_bit();
  logic out;
  out = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) lfsr_state = lfsr_state ^ 32'h8020_0003; // x^32+x^22+x^2+x+1
  return out;
endfunction

function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

`endif

// ==== tb/decode_queue_tb.sv ====
// Testbench for the instruction-decode queue
// Directed tests over format decode, ALU selects, back-pressure and a random stream

module decode_queue_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import decode_pkg::*;

  localparam int DEPTH          = 8;
  localparam int RESET_CYCLES   = 4;
  localparam int DRAIN_LIMIT    = 50;
  localparam int RANDOM_COUNT   = 200;
  localparam int T_FORMATS      = 100;  // Cycle budgets per test
  localparam int T_ALU          = 200;
  localparam int T_BACKPRESSURE = 150;
  localparam int T_RANDOM       = 2000;
  localparam int WATCHDOG_CYCLES =
    2 * (RESET_CYCLES + T_FORMATS + T_ALU + T_BACKPRESSURE + T_RANDOM);

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] in_instr;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  instr_type_t out_instr_type;
  alu_op_t     out_alu_sel;
  logic        out_b_sel;
  logic        out_br_un;
  wb_sel_t     out_wb_sel;
  logic        out_rf_we;
  pc_sel_t     out_pc_sel;

  int errors    = 0;
  int checks    = 0;
  int accepted  = 0;
  int transfers = 0;

  `include "decode_model.svh"

  decode_queue #(
    .DEPTH(DEPTH)
  ) dut_i (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_instr       (in_instr),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_instr_type (out_instr_type),
    .out_alu_sel    (out_alu_sel),
    .out_b_sel      (out_b_sel),
    .out_br_un      (out_br_un),
    .out_wb_sel     (out_wb_sel),
    .out_rf_we      (out_rf_we),
    .out_pc_sel     (out_pc_sel)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    errors++;
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    finish_run();
  end

  // Scoreboard for both ports, outputs first since latency is at least 2
  always @(posedge clk) begin : monitor_blk
    ctrl_word_t exp_w;
    if (!rst) begin
      if (out_valid && out_ready) begin
        transfers++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output transfer at %0t ns with no word pending", $time);
        end else begin
          exp_w = exp_q.pop_front();
          check_value("out_instr_type", out_instr_type, exp_w.instr_type);
          check_value("out_alu_sel", out_alu_sel, exp_w.alu_sel);
          check_value("out_b_sel", out_b_sel, exp_w.b_sel);
          check_value("out_br_un", out_br_un, exp_w.br_un);
          check_value("out_wb_sel", out_wb_sel, exp_w.wb_sel);
          check_value("out_rf_we", out_rf_we, exp_w.rf_we);
          check_value("out_pc_sel", out_pc_sel, exp_w.pc_sel);
        end
      end
      if (in_valid && in_ready) begin
        accepted++;
        expect_instr(in_instr);
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s = 0x%0h, expected 0x%0h at %0t ns", name, actual, expected, $time);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, words out: %0d", checks, errors, transfers);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [6:0] op);
    return {f7, 5'd3, 5'd2, f3, 5'd1, op}; // rs2=x3 rs1=x2 rd=x1
  endfunction

  function automatic logic [6:0] opcode_at(input int idx);
    case (idx % 8)
      0: return OP_R;
      1: return OP_I;
      2: return OP_S;
      3: return OP_B;
      4: return OP_LUI;
      5: return OP_AUIPC;
      6: return OP_J;
      default: return 7'b0000011; // Load, not decoded here
    endcase
  endfunction

  function automatic logic [31:0] random_instr();
    logic [2:0]  pick;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [14:0] regs;
    pick = 3'(lfsr_bits(3));
    if (pick == 3'd7) op = 7'(lfsr_bits(7)); // Mostly illegal
    else op = opcode_at(pick);
    f3   = 3'(lfsr_bits(3));
    f7   = lfsr_bit() ? F7_ALT : 7'h00;
    regs = 15'(lfsr_bits(15));
    return {f7, regs[14:10], regs[9:5], f3, regs[4:0], op};
  endfunction

  // Returns at the falling edge before the accepting rising edge
  task automatic send_instr(input logic [31:0] instr);
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = instr;
    while (!in_ready) @(negedge clk);
  endtask

  task automatic release_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input string test_name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d words never left the queue", test_name, exp_q.size());
    end
    check_value("out_valid", out_valid, 1'b0);
  endtask

  task automatic check_reset_state();
    check_value("out_valid", out_valid, 1'b0);
    check_value("in_ready", in_ready, 1'b1);
  endtask

  task automatic test_formats();
    @(negedge clk);
    out_ready = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_instr(make_instr(7'h00, 3'(i), opcode_at(i)));
    end
    release_input();
    wait_drain("format test");
  endtask

  task automatic test_alu_table();
    for (int f = 0; f < 8; f++) send_instr(make_instr(7'h00, 3'(f), OP_R));
    send_instr(make_instr(F7_ALT, 3'b000, OP_R)); // SUB
    send_instr(make_instr(F7_ALT, 3'b101, OP_R)); // SRA
    for (int f = 0; f < 8; f++) send_instr(make_instr(F7_ALT, 3'(f), OP_I));
    send_instr(make_instr(7'h00, 3'b101, OP_I));
    for (int f = 0; f < 8; f++) send_instr(make_instr(7'h00, 3'(f), OP_B));
    release_input();
    wait_drain("ALU table test");
  endtask

  task automatic test_backpressure();
    int   base_in;
    int   base_out;
    int   idx;
    logic take;
    base_in  = accepted;
    base_out = transfers;
    idx      = 0;
    take     = 1'b0;
    repeat (40) begin
      @(negedge clk);
      if (take) idx++;
      out_ready = 1'b0;
      in_valid  = 1'b1;
      in_instr  = make_instr(idx[0] ? F7_ALT : 7'h00, 3'(idx), opcode_at(idx));
      take      = in_ready;
    end
    release_input();
    check_value("accepted_count", accepted - base_in, DEPTH + 2);
    check_value("in_ready", in_ready, 1'b0);
    out_ready = 1'b1;
    wait_drain("back-pressure test");
    check_value("transfer_count", transfers - base_out, DEPTH + 2);
  endtask

  task automatic test_random_stream();
    int          base_out;
    int          sent;
    logic        take;
    logic [31:0] instr_now;
    base_out  = transfers;
    sent      = 0;
    take      = 1'b0;
    instr_now = random_instr();
    while (sent < RANDOM_COUNT) begin
      @(negedge clk);
      if (take) begin
        sent++;
        instr_now = random_instr();
      end
      in_valid  = (sent < RANDOM_COUNT) && (lfsr_bits(2) != '0); // About 3 in 4 cycles
      in_instr  = instr_now;
      out_ready = lfsr_bit();
      take      = in_valid && in_ready;
    end
    out_ready = 1'b1;
    wait_drain("random stream test");
    check_value("transfer_count", transfers - base_out, RANDOM_COUNT);
  endtask

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_instr  = '0;
    out_ready = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    test_formats();
    test_alu_table();
    test_backpressure();
    test_random_stream();
    finish_run();
  end

endmodule

// ==== verilog.f ====
+incdir+tb
logic/decode_pkg.sv
logic/ctrl_decoder.sv
logic/ctrl_buffer.sv
logic/ctrl_issue.sv
logic/decode_queue.sv
tb/decode_queue_tb.sv

// ==== Bender.yml ====
package:
  name: decode_queue

sources:
  - files:
      - logic/decode_pkg.sv
      - logic/ctrl_decoder.sv
      - logic/ctrl_buffer.sv
      - logic/ctrl_issue.sv
      - logic/decode_queue.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/decode_queue_tb.sv
